//--- hw/board_pkg.sv
`default_nettype none

package board_pkg;

    //////////////////////////////////////////////////
    // PLL lock watchdog
    //////////////////////////////////////////////////

    // Watchdog down-counter
    typedef logic [7:0] pll_cnt_t;

    // Loaded when lock is lost
    localparam pll_cnt_t PLL_RST_CYCLES = 8'd255;

    // Counter value out of RESET
    localparam pll_cnt_t PLL_CNT_INIT = 8'd208;

    //////////////////////////////////////////////////
    // Game reset stretcher
    //////////////////////////////////////////////////

    // Cycles that game reset outlasts the request
    localparam int unsigned GAME_RST_HOLD = 16;

    typedef logic [4:0] hold_cnt_t;

    // Last hold count, the synchroniser release covers two of the cycles
    localparam hold_cnt_t HOLD_LAST = hold_cnt_t'(GAME_RST_HOLD - 2);

    typedef enum logic [1:0] {
        ST_RESET,
        ST_HOLD,
        ST_RUN
    } game_rst_state_t;

endpackage

`default_nettype wire

//--- hw/av_pkg.sv
`default_nettype none

package av_pkg;

    //////////////////////////////////////////////////
    // Audio
    //////////////////////////////////////////////////

    // One channel sample
    typedef logic [15:0] sample_t;

    //////////////////////////////////////////////////
    // Pixel clock enables
    //////////////////////////////////////////////////

    // clk_sys cycles per pixel enable
    localparam int unsigned CEN_DIV = 8;

    typedef logic [2:0] cen_cnt_t;

    // Divider phase for pxl_cen
    localparam cen_cnt_t CEN_LAST = cen_cnt_t'(CEN_DIV - 1);

    // Low bits that repeat at the double rate
    localparam cen_cnt_t CEN2_MASK = cen_cnt_t'(CEN_DIV / 2 - 1);

endpackage

`default_nettype wire

//--- hw/rst_sync.sv
`default_nettype none

module rst_sync (
    input  logic clk,
    input  logic rst,
    output logic rst_sync
);

    logic meta_q;

    // Assert at once, release on the second edge
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            meta_q   <= 1'b1;
            rst_sync <= 1'b1;
        end else begin
            meta_q   <= 1'b0;
            rst_sync <= meta_q;
        end
    end

endmodule

`default_nettype wire

//--- hw/pll_lock_watch.sv
`default_nettype none

module pll_lock_watch (
    input  logic clk_sys,
    input  logic RESET,
    input  logic pll_locked,
    output logic pll_rst
);
    import board_pkg::*;

    logic     lock_q;
    logic     lock_fall;
    logic     cnt_done;
    pll_cnt_t rst_cnt;

    // Lock was high last cycle and is low now
    assign lock_fall = lock_q & ~pll_locked;

    always_ff @(posedge clk_sys or posedge RESET) begin
        if (RESET) begin
            lock_q   <= 1'b0;
            pll_rst  <= 1'b0;
            cnt_done <= 1'b0;
            rst_cnt  <= PLL_CNT_INIT;
        end else begin
            lock_q <= pll_locked;
            if (lock_fall) begin
                // Restart the count, also while already in PLL reset
                pll_rst  <= 1'b1;
                cnt_done <= 1'b0;
                rst_cnt  <= PLL_RST_CYCLES;
            end else if (rst_cnt != '0) begin
                cnt_done <= 1'b0;
                rst_cnt  <= rst_cnt - pll_cnt_t'(1);
            end else begin
                // Release one cycle after the counter has been seen at zero
                cnt_done <= 1'b1;
                if (cnt_done) begin
                    pll_rst <= 1'b0;
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    // PLL reset only starts from a lock drop one cycle earlier
    a_rst_after_fall: assert property (
        @(posedge clk_sys) disable iff (RESET)
        $rose(pll_rst) |-> $past(lock_fall)
    ) else $error("pll_rst rose without a lock drop");

endmodule

`default_nettype wire

//--- hw/game_reset.sv
`default_nettype none

module game_reset (
    input  logic clk_sys,
    input  logic RESET,
    input  logic status_rst,
    input  logic button_rst,
    input  logic downloading,
    input  logic pll_rst,
    output logic game_rst
);
    import board_pkg::*;

    logic            req_any;
    logic            req_q;
    logic            req_sync;
    game_rst_state_t state;
    hold_cnt_t       hold_cnt;

    // All reset sources
    assign req_any = status_rst | button_rst | downloading | pll_rst;

    // Request register, counts as a request while RESET is high
    always_ff @(posedge clk_sys or posedge RESET) begin
        if (RESET) begin
            req_q <= 1'b1;
        end else begin
            req_q <= req_any;
        end
    end

    rst_sync u_req_sync (
        .clk      (clk_sys),
        .rst      (req_q),
        .rst_sync (req_sync)
    );

    //////////////////////////////////////////////////
    // Reset FSM
    //////////////////////////////////////////////////

    always_ff @(posedge clk_sys or posedge RESET) begin
        if (RESET) begin
            state    <= ST_RESET;
            hold_cnt <= '0;
            game_rst <= 1'b1;
        end else begin
            // Registered, high in ST_RESET and ST_HOLD
            game_rst <= (state != ST_RUN);
            if (req_sync) begin
                state    <= ST_RESET;
                hold_cnt <= '0;
            end else begin
                case (state)
                    ST_RESET: begin
                        state    <= ST_HOLD;
                        hold_cnt <= '0;
                    end
                    ST_HOLD: begin
                        if (hold_cnt == HOLD_LAST) begin
                            state <= ST_RUN;
                        end else begin
                            hold_cnt <= hold_cnt + hold_cnt_t'(1);
                        end
                    end
                    default: begin
                        state <= ST_RUN;
                    end
                endcase
            end
        end
    end

    // Game reset follows a synchronised request within two cycles
    a_req_to_rst: assert property (
        @(posedge clk_sys) disable iff (RESET)
        req_sync |-> ##2 game_rst
    ) else $error("game_rst missing after a reset request");

endmodule

`default_nettype wire

//--- hw/pixel_cen.sv
`default_nettype none

module pixel_cen (
    input  logic clk_sys,
    input  logic RESET,
    input  logic game_rst,
    output logic pxl2_cen,
    output logic pxl_cen,
    output logic pxl1_cen
);
    import av_pkg::*;

    cen_cnt_t cen_cnt;

    //////////////////////////////////////////////////
    // Divider and enables
    //////////////////////////////////////////////////

    always_ff @(posedge clk_sys or posedge RESET) begin
        if (RESET) begin
            cen_cnt  <= '0;
            pxl2_cen <= 1'b0;
            pxl_cen  <= 1'b0;
            pxl1_cen <= 1'b0;
        end else begin
            // Places pxl1_cen between two pixel enables
            pxl1_cen <= pxl2_cen & ~pxl_cen;
            if (game_rst) begin
                cen_cnt  <= '0;
                pxl2_cen <= 1'b0;
                pxl_cen  <= 1'b0;
            end else begin
                // Wraps every CEN_DIV cycles
                cen_cnt  <= cen_cnt + cen_cnt_t'(1);
                pxl2_cen <= (cen_cnt & CEN2_MASK) == CEN2_MASK;
                pxl_cen  <= (cen_cnt == CEN_LAST);
            end
        end
    end

    // Each pixel enable is also a double-rate enable, with one more four cycles back
    a_cen_nested: assert property (
        @(posedge clk_sys) disable iff (RESET)
        pxl_cen |-> pxl2_cen && $past(pxl2_cen, 4)
    ) else $error("pxl_cen out of step with pxl2_cen");

endmodule

`default_nettype wire

//--- hw/audio_out.sv
`default_nettype none

module audio_out (
    input  logic            clk_audio,
    input  logic            RESET,
    input  logic            game_rst,
    input  av_pkg::sample_t snd_left,
    input  av_pkg::sample_t snd_right,
    output av_pkg::sample_t audio_l,
    output av_pkg::sample_t audio_r
);
    import av_pkg::*;

    logic    mute;
    sample_t left_q;
    sample_t right_q;

    // Game reset seen from the audio clock
    rst_sync u_mute_sync (
        .clk      (clk_audio),
        .rst      (game_rst),
        .rst_sync (mute)
    );

    //////////////////////////////////////////////////
    // Resynchroniser
    //////////////////////////////////////////////////

    // First stage takes the clk_sys samples
    always_ff @(posedge clk_audio) begin
        left_q  <= snd_left;
        right_q <= snd_right;
    end

    always_ff @(posedge clk_audio or posedge RESET) begin
        if (RESET) begin
            audio_l <= '0;
            audio_r <= '0;
        end else if (mute) begin
            audio_l <= '0;
            audio_r <= '0;
        end else begin
            audio_l <= left_q;
            audio_r <= right_q;
        end
    end

    // Silence follows the mute on the next audio edge
    a_mute_silent: assert property (
        @(posedge clk_audio) disable iff (RESET)
        mute |=> (audio_l == '0) && (audio_r == '0)
    ) else $error("audio not silent while muted");

endmodule

`default_nettype wire

//--- hw/core_glue.sv
`default_nettype none

module core_glue (
    input  logic            clk_sys,
    input  logic            clk_audio,
    input  logic            RESET,
    input  logic            pll_locked,
    input  logic            status_rst,
    input  logic            button_rst,
    input  logic            downloading,
    input  av_pkg::sample_t snd_left,
    input  av_pkg::sample_t snd_right,
    output logic            pll_rst,
    output logic            game_rst,
    output logic            pxl2_cen,
    output logic            pxl_cen,
    output logic            pxl1_cen,
    output av_pkg::sample_t audio_l,
    output av_pkg::sample_t audio_r
);

    //////////////////////////////////////////////////
    // Clock and reset
    //////////////////////////////////////////////////

    pll_lock_watch u_pll_watch (
        .clk_sys    (clk_sys),
        .RESET      (RESET),
        .pll_locked (pll_locked),
        .pll_rst    (pll_rst)
    );

    // PLL reset also holds the game in reset
    game_reset u_game_reset (
        .clk_sys     (clk_sys),
        .RESET       (RESET),
        .status_rst  (status_rst),
        .button_rst  (button_rst),
        .downloading (downloading),
        .pll_rst     (pll_rst),
        .game_rst    (game_rst)
    );

    //////////////////////////////////////////////////
    // Video and audio
    //////////////////////////////////////////////////

    pixel_cen u_pixel_cen (
        .clk_sys  (clk_sys),
        .RESET    (RESET),
        .game_rst (game_rst),
        .pxl2_cen (pxl2_cen),
        .pxl_cen  (pxl_cen),
        .pxl1_cen (pxl1_cen)
    );

    audio_out u_audio_out (
        .clk_audio (clk_audio),
        .RESET     (RESET),
        .game_rst  (game_rst),
        .snd_left  (snd_left),
        .snd_right (snd_right),
        .audio_l   (audio_l),
        .audio_r   (audio_r)
    );

endmodule

`default_nettype wire

//--- tests/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// Fibonacci LFSR, taps 32 22 2 1
logic [31:0] lfsr_state = 32'ha2f7_d1e3;

function automatic logic lfsr_step();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
endfunction

// One LFSR step per bit taken
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        v = {v[30:0], lfsr_step()};
    end
    return v;
endfunction

//////////////////////////////////////////////////
// Reference model, one step per clk_sys edge
//////////////////////////////////////////////////

logic               m_lock_q;
int                 m_pll_left;
logic               m_pll_rst;
logic [GAME_FALL:0] m_req_hist;
logic               m_game_rst;
int                 m_phase;
logic               m_pxl2;
logic               m_pxl;
logic               m_pxl1;
int                 m_pll_pulses;
int                 m_pll_restarts;
int                 m_game_rises;
int                 m_pxl_count;

task automatic model_reset();
    m_lock_q       = 1'b0;
    m_pll_left     = 0;
    m_pll_rst      = 1'b0;
    // RESET counts as a request up to the release
    m_req_hist     = '1;
    m_game_rst     = 1'b1;
    m_phase        = 0;
    m_pxl2         = 1'b0;
    m_pxl          = 1'b0;
    m_pxl1         = 1'b0;
    m_pll_pulses   = 0;
    m_pll_restarts = 0;
    m_game_rises   = 0;
    m_pxl_count    = 0;
endtask

task automatic model_sys_step(input logic locked, input logic ext_req);
    logic req;
    logic pll_next;
    logic game_next;
    req = ext_req | m_pll_rst;
    if (m_lock_q && !locked) begin
        if (m_pll_rst) begin
            m_pll_restarts++;
        end
        m_pll_left = PLL_HIGH;
    end else if (m_pll_left > 0) begin
        m_pll_left--;
    end
    pll_next = (m_pll_left > 0);
    m_lock_q = locked;
    // Game reset high while a request lies 2 to GAME_FALL edges back
    m_req_hist = {m_req_hist[GAME_FALL-1:0], req};
    game_next  = |m_req_hist[GAME_FALL:2];
    // Enables follow the game reset of the previous cycle
    m_pxl1 = m_pxl2 & ~m_pxl;
    if (m_game_rst) begin
        m_phase = 0;
        m_pxl2  = 1'b0;
        m_pxl   = 1'b0;
    end else begin
        m_pxl2  = (m_phase % HALF_DIV) == HALF_DIV - 1;
        m_pxl   = (m_phase == FULL_DIV - 1);
        m_phase = (m_phase + 1) % FULL_DIV;
    end
    if (pll_next && !m_pll_rst) begin
        m_pll_pulses++;
    end
    if (game_next && !m_game_rst) begin
        m_game_rises++;
    end
    if (m_pxl) begin
        m_pxl_count++;
    end
    m_pll_rst  = pll_next;
    m_game_rst = game_next;
endtask

`endif

//--- tests/tb_core_glue.sv
`default_nettype none

module tb_core_glue;
    import board_pkg::*;
    import av_pkg::*;

    localparam int PLL_HIGH       = int'(PLL_RST_CYCLES) + 2;
    localparam int GAME_FALL      = int'(GAME_RST_HOLD) + 3;
    localparam int FULL_DIV       = int'(CEN_DIV);
    localparam int HALF_DIV       = FULL_DIV / 2;
    localparam int RUN_CYCLES     = 6000;
    localparam int TIMEOUT_CYCLES = 20000;
    localparam int LOCK_DROP_AT   = 60;
    localparam int STATUS_AT      = 600;
    localparam int RANDOM_FROM    = 700;

    logic    clk_sys;
    logic    clk_audio;
    logic    RESET;
    logic    pll_locked;
    logic    status_rst;
    logic    button_rst;
    logic    downloading;
    sample_t snd_left;
    sample_t snd_right;
    logic    pll_rst;
    logic    game_rst;
    logic    pxl2_cen;
    logic    pxl_cen;
    logic    pxl1_cen;
    sample_t audio_l;
    sample_t audio_r;

    int      errors;
    int      checks;
    int      sys_cycles;
    int      lock_low_left;
    int      restart_at;
    int      pulse_left;
    int      pulse_src;
    sample_t snd_prev_l;
    sample_t snd_prev_r;
    time     snd_change_time;
    int      aud_high;
    int      aud_low;
    int      aud_hits;
    int      aud_mutes;

    `include "tb_model.svh"

    core_glue DUT (
        .clk_sys     (clk_sys),
        .clk_audio   (clk_audio),
        .RESET       (RESET),
        .pll_locked  (pll_locked),
        .status_rst  (status_rst),
        .button_rst  (button_rst),
        .downloading (downloading),
        .snd_left    (snd_left),
        .snd_right   (snd_right),
        .pll_rst     (pll_rst),
        .game_rst    (game_rst),
        .pxl2_cen    (pxl2_cen),
        .pxl_cen     (pxl_cen),
        .pxl1_cen    (pxl1_cen),
        .audio_l     (audio_l),
        .audio_r     (audio_r)
    );

    initial begin
        clk_sys = 1'b0;
        forever #5 clk_sys = ~clk_sys;
    end

    initial begin
        clk_audio = 1'b0;
        forever #7 clk_audio = ~clk_audio;
    end

    task automatic expect_bit(input string what, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED @%0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic expect_word(input string what, input sample_t got, input sample_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED @%0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic compare_sys();
        expect_bit("pll_rst", pll_rst, m_pll_rst);
        expect_bit("game_rst", game_rst, m_game_rst);
        expect_bit("pxl2_cen", pxl2_cen, m_pxl2);
        expect_bit("pxl_cen", pxl_cen, m_pxl);
        expect_bit("pxl1_cen", pxl1_cen, m_pxl1);
    endtask

    //////////////////////////////////////////////////
    // Stimulus for the next clk_sys edge
    //////////////////////////////////////////////////

    task automatic drive_inputs(input int c);
        logic [31:0] r;
        if (c == LOCK_DROP_AT) begin
            lock_low_left = 1 + int'(rand_bits(2));
            // Second drop well inside the first PLL reset
            restart_at = c + 100 + int'(rand_bits(7));
        end
        if (c == restart_at) begin
            lock_low_left = 1 + int'(rand_bits(2));
        end
        if (c == STATUS_AT) begin
            pulse_src  = 0;
            pulse_left = 3;
        end
        if (c >= RANDOM_FROM && pulse_left == 0 && lock_low_left == 0) begin
            if (rand_bits(6) == 0) begin
                pulse_left = 1 + int'(rand_bits(3));
                pulse_src  = int'(rand_bits(2)) % 3;
            end else if (rand_bits(10) == 0) begin
                lock_low_left = 1 + int'(rand_bits(2));
            end
        end
        pll_locked  = (lock_low_left == 0);
        status_rst  = (pulse_left > 0) && (pulse_src == 0);
        button_rst  = (pulse_left > 0) && (pulse_src == 1);
        downloading = (pulse_left > 0) && (pulse_src == 2);
        if (lock_low_left > 0) begin
            lock_low_left--;
        end
        if (pulse_left > 0) begin
            pulse_left--;
        end
        // New stereo sample every 8 cycles
        if (c % 8 == 0) begin
            snd_prev_l      = snd_left;
            snd_prev_r      = snd_right;
            r               = rand_bits(32);
            snd_left        = r[31:16];
            snd_right       = r[15:0];
            snd_change_time = $time;
        end
    endtask

    //////////////////////////////////////////////////
    // Audio checks 1 unit after each clk_audio edge
    //////////////////////////////////////////////////

    always @(posedge clk_audio) begin
        #1;
        if (RESET) begin
            aud_high = 0;
            aud_low  = 0;
        end else begin
            if (game_rst) begin
                aud_high++;
                aud_low = 0;
            end else begin
                aud_low++;
                aud_high = 0;
            end
            if (aud_high >= 3) begin
                aud_mutes++;
                expect_word("audio_l", audio_l, '0);
                expect_word("audio_r", audio_r, '0);
            end else if (aud_low >= 4) begin
                aud_hits++;
                // Output holds the sample seen at the previous audio edge
                if (snd_change_time <= $time - 15) begin
                    expect_word("audio_l", audio_l, snd_left);
                    expect_word("audio_r", audio_r, snd_right);
                end else begin
                    expect_word("audio_l", audio_l, snd_prev_l);
                    expect_word("audio_r", audio_r, snd_prev_r);
                end
            end
        end
    end

    initial begin
        sys_cycles = 0;
        while (sys_cycles < TIMEOUT_CYCLES) begin
            @(posedge clk_sys);
            sys_cycles++;
        end
        $display("Timeout, run did not end within %0d clk_sys cycles", TIMEOUT_CYCLES);
        $display("** FAIL **");
        $finish;
    end

    initial begin
        errors          = 0;
        checks          = 0;
        aud_high        = 0;
        aud_low         = 0;
        aud_hits        = 0;
        aud_mutes       = 0;
        lock_low_left   = 0;
        restart_at      = -1;
        pulse_left      = 0;
        pulse_src       = 0;
        RESET           = 1'b1;
        pll_locked      = 1'b1;
        status_rst      = 1'b0;
        button_rst      = 1'b0;
        downloading     = 1'b0;
        snd_left        = '0;
        snd_right       = '0;
        snd_prev_l      = '0;
        snd_prev_r      = '0;
        snd_change_time = 0;
        model_reset();
        repeat (10) @(posedge clk_sys);
        #1;
        compare_sys();
        expect_word("audio_l", audio_l, '0);
        expect_word("audio_r", audio_r, '0);
        RESET = 1'b0;
        for (int c = 0; c < RUN_CYCLES; c++) begin
            @(posedge clk_sys);
            #1;
            model_sys_step(pll_locked, status_rst | button_rst | downloading);
            compare_sys();
            drive_inputs(c);
        end
        // Every behaviour must have been reached
        if (m_pll_pulses < 2 || m_pll_restarts < 1) begin
            errors++;
            $display("Too few lock drops or no restarted PLL reset were seen");
        end
        if (m_game_rises < 3 || m_pxl_count == 0) begin
            errors++;
            $display("Game reset or pixel enables were not exercised");
        end
        if (aud_hits == 0 || aud_mutes == 0) begin
            errors++;
            $display("Audio samples or muting were never checked");
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
+incdir+tests
hw/board_pkg.sv
hw/av_pkg.sv
hw/rst_sync.sv
hw/pll_lock_watch.sv
hw/game_reset.sv
hw/pixel_cen.sv
hw/audio_out.sv
hw/core_glue.sv
tests/tb_core_glue.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_core_glue
FILELIST  = list.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qF '** PASS **' $(LOG); then \
		echo "Result: passed"; \
	else \
		echo "Result: failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
